// ==== list.f ====
+incdir+source
source/host_exer_pkg.sv
source/engine_csr_if.sv
source/host_mem_rdwr_engine.sv
source/csr_mgr.sv
source/afu.sv
sim/afu_tb.sv

// ==== Makefile ====
# Verilator build and run of the host memory exerciser testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module afu_tb -Mdir obj_dir -f list.f

run: compile
	./obj_dir/Vafu_tb > sim.log 2>&1; cat sim.log
	@if grep -q "Errors found" sim.log; then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q "No errors" sim.log; then \
		echo "Simulation ended without a result"; exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir sim.log

// ==== sim/afu_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "host_exer_config.svh"

module afu_tb import host_exer_pkg::*; ();

    localparam int NE = `HE_NUM_ENGINES;
    localparam int DW = `HE_DATA_W;
    localparam int AW = `HE_ADDR_W;

    // Longest test moves about two hundred lines, so this is a wide margin
    localparam int MAX_CYCLES = 20000;

    logic                       clk;
    logic                       rst_n;
    logic                       mmio_wr;
    logic                       mmio_rd;
    logic [`HE_MMIO_ADDR_W-1:0] mmio_addr;
    logic [DW-1:0]              mmio_wr_data;
    logic                       mmio_rd_valid;
    logic [DW-1:0]              mmio_rd_data;
    logic [NE-1:0]              mem_wr;
    logic [NE-1:0]              mem_rd;
    logic [NE*AW-1:0]           mem_addr;
    logic [NE*DW-1:0]           mem_wr_data;
    logic [NE-1:0]              mem_rsp_valid;
    logic [NE*DW-1:0]           mem_rsp_data;

    afu dut
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .mmio_wr      (mmio_wr),
        .mmio_rd      (mmio_rd),
        .mmio_addr    (mmio_addr),
        .mmio_wr_data (mmio_wr_data),
        .mmio_rd_valid(mmio_rd_valid),
        .mmio_rd_data (mmio_rd_data),
        .mem_wr       (mem_wr),
        .mem_rd       (mem_rd),
        .mem_addr     (mem_addr),
        .mem_wr_data  (mem_wr_data),
        .mem_rsp_valid(mem_rsp_valid),
        .mem_rsp_data (mem_rsp_data)
    );

    always #50 clk = ~clk;

    // ====================
    // Memory models
    // ====================

    logic [DW-1:0] mem        [NE][65536];
    logic [DW-1:0] rsp_data_q [NE][$];
    int            rsp_due_q  [NE][$];
    int            last_due   [NE];
    int            wr_seen    [NE];
    int            rd_seen    [NE];
    int            cycle;
    logic [15:0]   lfsr;
    int            errors;
    int            checks;
    int            tests;

    // Galois LFSR, one step per bit handed out
    function automatic logic [DW-1:0] lfsr_bits(input int n);
        logic [DW-1:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v    = {v[DW-2:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return v;
    endfunction

    // Requests are taken on the rising edge
    always @(posedge clk)
    begin
        int due;
        cycle = cycle + 1;
        if (cycle > MAX_CYCLES)
        begin
            $display("Timeout: the run passed %0d cycles without finishing", MAX_CYCLES);
            $display("Errors found");
            $finish;
        end
        else
        begin
            for (int e = 0; e < NE; e++)
            begin
                if (mem_wr[e])
                begin
                    mem[e][mem_addr[e*AW +: AW]] = mem_wr_data[e*DW +: DW];
                    wr_seen[e]++;
                end
                if (mem_rd[e])
                begin
                    // Two LFSR bits give a latency of 1 to 4 cycles
                    due = cycle + int'(lfsr_bits(2));
                    // Responses stay in order, one per cycle at most
                    if (due <= last_due[e])
                        due = last_due[e] + 1;
                    last_due[e] = due;
                    rsp_data_q[e].push_back(mem[e][mem_addr[e*AW +: AW]]);
                    rsp_due_q[e].push_back(due);
                    rd_seen[e]++;
                end
            end
        end
    end

    // Responses are driven on the falling edge, like all stimulus
    always @(negedge clk)
    begin
        for (int e = 0; e < NE; e++)
        begin
            mem_rsp_valid[e]         = 1'b0;
            mem_rsp_data[e*DW +: DW] = '0;
            if (rsp_due_q[e].size() > 0 && rsp_due_q[e][0] <= cycle)
            begin
                mem_rsp_valid[e]         = 1'b1;
                mem_rsp_data[e*DW +: DW] = rsp_data_q[e].pop_front();
                void'(rsp_due_q[e].pop_front());
            end
        end
    end

    // ====================
    // Helpers and compare tasks
    // ====================

    task automatic check_data(input string name, input logic [DW-1:0] got,
                              input logic [DW-1:0] exp);
        checks++;
        if (got !== exp)
        begin
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_mode(input string name, input eng_mode_e got, input eng_mode_e exp);
        checks++;
        if (got !== exp)
        begin
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    // All bus tasks start and end on a falling edge
    task automatic mmio_write(input logic [`HE_MMIO_ADDR_W-1:0] addr, input logic [DW-1:0] data);
        mmio_wr      = 1'b1;
        mmio_addr    = addr;
        mmio_wr_data = data;
        @(negedge clk);
        mmio_wr      = 1'b0;
    endtask

    task automatic mmio_read(input logic [`HE_MMIO_ADDR_W-1:0] addr, output logic [DW-1:0] data);
        mmio_rd   = 1'b1;
        mmio_addr = addr;
        @(negedge clk);
        mmio_rd   = 1'b0;
        checks++;
        if (mmio_rd_valid !== 1'b1)
        begin
            $display("Read of word 0x%h got no mmio_rd_valid one cycle later", addr);
            errors++;
        end
        data = mmio_rd_data;
    endtask

    function automatic logic [`HE_MMIO_ADDR_W-1:0] eng_addr(input int e, input eng_csr_e idx);
        return `HE_MMIO_ADDR_W'(`HE_ENG_BASE + e * `HE_ENG_STRIDE + int'(idx));
    endfunction

    // Pattern rule: seed XOR the zero-extended line address
    function automatic logic [DW-1:0] pattern(input logic [DW-1:0] seed, input int a);
        return seed ^ DW'(a[AW-1:0]);
    endfunction

    // Mode as seen from the strobes on the memory port
    function automatic eng_mode_e seen_mode(input int e);
        if (wr_seen[e] > 0 && rd_seen[e] > 0)
            return MODE_RDWR;
        if (wr_seen[e] > 0)
            return MODE_WRITE;
        return MODE_READ;
    endfunction

    task automatic start_engine(input int e, input eng_mode_e mode, input int base,
                                input int lines, input logic [DW-1:0] seed);
        mmio_write(eng_addr(e, CSR_BASE), DW'(base));
        mmio_write(eng_addr(e, CSR_LINES), DW'(lines));
        mmio_write(eng_addr(e, CSR_SEED), seed);
        wr_seen[e] = 0;
        rd_seen[e] = 0;
        // Start is bit 8, mode sits in bits 1:0
        mmio_write(eng_addr(e, CSR_CTRL), 64'h100 | DW'(mode));
    endtask

    task automatic wait_done(input int e);
        logic [DW-1:0] st;
        st = '0;
        while (st[1] !== 1'b1)
            mmio_read(eng_addr(e, CSR_STATUS), st);
    endtask

    task automatic finish_engine(input int e, input eng_mode_e mode, input int lines);
        logic [DW-1:0] st;
        wait_done(e);
        mmio_read(eng_addr(e, CSR_STATUS), st);
        check_data($sformatf("engine %0d status", e), st, 64'h2);
        check_mode($sformatf("engine %0d mode", e), seen_mode(e), mode);
        check_data($sformatf("engine %0d write count", e), DW'(wr_seen[e]),
                   (mode != MODE_READ) ? DW'(lines) : '0);
        check_data($sformatf("engine %0d read count", e), DW'(rd_seen[e]),
                   (mode != MODE_WRITE) ? DW'(lines) : '0);
    endtask

    task automatic end_test(input string name, input int err_before);
        tests++;
        if (errors == err_before)
            $display("%s: pass", name);
        else
            $display("%s: FAIL with %0d errors", name, errors - err_before);
    endtask

    // ====================
    // Tests
    // ====================

    task automatic test_reset_globals();
        logic [DW-1:0] d;
        int            e0;
        e0 = errors;
        check_data("mem_wr", DW'(mem_wr), '0);
        check_data("mem_rd", DW'(mem_rd), '0);
        check_data("mmio_rd_valid", DW'(mmio_rd_valid), '0);
        mmio_read(0, d);
        check_data("test id low", d, `HE_TEST_ID_LO);
        mmio_read(1, d);
        check_data("test id high", d, `HE_TEST_ID_HI);
        mmio_read(2, d);
        check_data("engine count", d, DW'(NE));
        mmio_write(3, 64'h5a5a_0123_fedc_a5a5);
        mmio_read(3, d);
        check_data("scratch", d, 64'h5a5a_0123_fedc_a5a5);
        // Valid is a single pulse per read
        @(negedge clk);
        check_data("mmio_rd_valid after pulse", DW'(mmio_rd_valid), '0);
        for (int e = 0; e < NE; e++)
        begin
            mmio_read(eng_addr(e, CSR_STATUS), d);
            check_data($sformatf("engine %0d status after reset", e), d, '0);
        end
        mmio_read(`HE_MMIO_ADDR_W'(`HE_ENG_BASE + NE * `HE_ENG_STRIDE), d);
        check_data("word past last engine", d, '0);
        end_test("reset_and_globals", e0);
    endtask

    task automatic test_write_mode();
        logic [DW-1:0] seed;
        int            e0;
        e0   = errors;
        seed = 64'hc0de_0000_1234_0000;
        start_engine(0, MODE_WRITE, 'h100, 32, seed);
        finish_engine(0, MODE_WRITE, 32);
        for (int a = 'h100; a < 'h120; a++)
            check_data($sformatf("memory 0 line 0x%h", a), mem[0][a], pattern(seed, a));
        end_test("write_mode", e0);
    endtask

    task automatic test_rdwr_mode();
        logic [DW-1:0] seed;
        logic [DW-1:0] exp;
        logic [DW-1:0] d;
        int            e0;
        e0   = errors;
        seed = 64'h0f0f_7788_9abc_0001;
        exp  = '0;
        for (int a = 'h2000; a < 'h2018; a++)
            exp ^= pattern(seed, a);
        start_engine(1, MODE_RDWR, 'h2000, 24, seed);
        finish_engine(1, MODE_RDWR, 24);
        mmio_read(eng_addr(1, CSR_CHECKSUM), d);
        check_data("engine 1 checksum", d, exp);
        mmio_read(eng_addr(1, CSR_CYCLES), d);
        checks++;
        if (d < 48)
        begin
            $display("Cycle count %0d is shorter than two passes over 24 lines", d);
            errors++;
        end
        end_test("rdwr_mode", e0);
    endtask

    task automatic test_read_mode();
        logic [DW-1:0] exp;
        logic [DW-1:0] d;
        int            e0;
        e0  = errors;
        exp = '0;
        for (int a = 'h3000; a < 'h3014; a++)
        begin
            mem[0][a] = lfsr_bits(DW);
            exp ^= mem[0][a];
        end
        start_engine(0, MODE_READ, 'h3000, 20, 64'h1);
        finish_engine(0, MODE_READ, 20);
        mmio_read(eng_addr(0, CSR_CHECKSUM), d);
        check_data("engine 0 checksum", d, exp);
        end_test("read_mode", e0);
    endtask

    task automatic test_concurrent_edges();
        logic [DW-1:0] exp;
        logic [DW-1:0] d;
        int            e0;
        e0  = errors;
        exp = '0;
        for (int a = 'h500; a < 'h510; a++)
        begin
            mem[1][a] = lfsr_bits(DW);
            exp ^= mem[1][a];
        end
        // Engine 0 is still writing when engine 1 starts reading
        start_engine(0, MODE_WRITE, 'h400, 48, 64'hbeef_0000_0000_0400);
        start_engine(1, MODE_READ, 'h500, 16, 64'h0);
        finish_engine(0, MODE_WRITE, 48);
        finish_engine(1, MODE_READ, 16);
        for (int a = 'h400; a < 'h430; a++)
            check_data($sformatf("memory 0 line 0x%h", a), mem[0][a],
                       pattern(64'hbeef_0000_0000_0400, a));
        mmio_read(eng_addr(1, CSR_CHECKSUM), d);
        check_data("engine 1 checksum", d, exp);
        // An empty run clears the old checksum
        start_engine(1, MODE_READ, 'h500, 0, 64'h0);
        finish_engine(1, MODE_READ, 0);
        mmio_read(eng_addr(1, CSR_CHECKSUM), d);
        check_data("engine 1 empty checksum", d, '0);
        // Second start in another mode arrives while the first run is busy
        exp = '0;
        for (int a = 'h600; a < 'h628; a++)
            exp ^= pattern(64'h1357_9bdf_0246_8ace, a);
        start_engine(0, MODE_RDWR, 'h600, 40, 64'h1357_9bdf_0246_8ace);
        mmio_write(eng_addr(0, CSR_CTRL), 64'h100 | DW'(MODE_WRITE));
        finish_engine(0, MODE_RDWR, 40);
        mmio_read(eng_addr(0, CSR_CHECKSUM), d);
        check_data("engine 0 checksum after ignored start", d, exp);
        end_test("concurrent_and_edges", e0);
    endtask

    initial
    begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        mmio_wr       = 1'b0;
        mmio_rd       = 1'b0;
        mmio_addr     = '0;
        mmio_wr_data  = '0;
        mem_rsp_valid = '0;
        mem_rsp_data  = '0;
        lfsr          = 16'd3;
        cycle         = 0;
        errors        = 0;
        checks        = 0;
        tests         = 0;
        for (int e = 0; e < NE; e++)
        begin
            last_due[e] = 0;
            wr_seen[e]  = 0;
            rd_seen[e]  = 0;
        end
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        test_reset_globals();
        test_write_mode();
        test_rdwr_mode();
        test_read_mode();
        test_concurrent_edges();
        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/afu.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "host_exer_config.svh"

module afu
(
    input  wire logic                                     clk,
    input  wire logic                                     rst_n,

    // Host register window
    input  wire logic                                     mmio_wr,
    input  wire logic                                     mmio_rd,
    input  wire logic [`HE_MMIO_ADDR_W-1:0]               mmio_addr,
    input  wire logic [`HE_DATA_W-1:0]                    mmio_wr_data,
    output logic                                          mmio_rd_valid,
    output logic [`HE_DATA_W-1:0]                         mmio_rd_data,

    // Memory ports, engine e owns bit e and slice e of each bus
    output logic [`HE_NUM_ENGINES-1:0]                    mem_wr,
    output logic [`HE_NUM_ENGINES-1:0]                    mem_rd,
    output logic [`HE_NUM_ENGINES*`HE_ADDR_W-1:0]         mem_addr,
    output logic [`HE_NUM_ENGINES*`HE_DATA_W-1:0]         mem_wr_data,
    input  wire logic [`HE_NUM_ENGINES-1:0]               mem_rsp_valid,
    input  wire logic [`HE_NUM_ENGINES*`HE_DATA_W-1:0]    mem_rsp_data
);

    localparam int NUM_ENGINES = `HE_NUM_ENGINES;

    // One register link per engine
    engine_csr_if eng_csr[NUM_ENGINES]();

    // ====================
    // Register manager
    // ====================

    csr_mgr
    #(
        .NUM_ENGINES  (NUM_ENGINES)
    )
    u_csr_mgr
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .mmio_wr      (mmio_wr),
        .mmio_rd      (mmio_rd),
        .mmio_addr    (mmio_addr),
        .mmio_wr_data (mmio_wr_data),
        .mmio_rd_valid(mmio_rd_valid),
        .mmio_rd_data (mmio_rd_data),
        .eng_csr      (eng_csr)
    );

    // ====================
    // Engines
    // ====================

    for (genvar e = 0; e < NUM_ENGINES; e++)
    begin : g_eng
        // Engine number follows its memory port index
        host_mem_rdwr_engine
        #(
            .ENGINE_NUMBER(e)
        )
        u_eng
        (
            .clk          (clk),
            .rst_n        (rst_n),
            .mem_wr       (mem_wr[e]),
            .mem_rd       (mem_rd[e]),
            .mem_addr     (mem_addr[e*`HE_ADDR_W +: `HE_ADDR_W]),
            .mem_wr_data  (mem_wr_data[e*`HE_DATA_W +: `HE_DATA_W]),
            .mem_rsp_valid(mem_rsp_valid[e]),
            .mem_rsp_data (mem_rsp_data[e*`HE_DATA_W +: `HE_DATA_W]),
            .csrs         (eng_csr[e])
        );
    end

endmodule

`default_nettype wire

// ==== source/csr_mgr.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "host_exer_config.svh"

module csr_mgr import host_exer_pkg::*;
#(
    parameter int NUM_ENGINES = `HE_NUM_ENGINES
)
(
    input  wire logic                      clk,
    input  wire logic                      rst_n,

    // Host register window
    input  wire logic                      mmio_wr,
    input  wire logic                      mmio_rd,
    input  wire logic [`HE_MMIO_ADDR_W-1:0] mmio_addr,
    input  wire logic [`HE_DATA_W-1:0]     mmio_wr_data,
    output logic                           mmio_rd_valid,
    output logic [`HE_DATA_W-1:0]          mmio_rd_data,

    // One register link per engine
    engine_csr_if.mgr                      eng_csr[NUM_ENGINES]
);

    // Engine blocks are a power of two apart, so selection is a shift
    localparam int STRIDE_SHIFT = $clog2(`HE_ENG_STRIDE);

    localparam logic [`HE_DATA_W-1:0] ENG_COUNT = NUM_ENGINES;

    // ====================
    // Address decode
    // ====================

    logic                       is_global;
    logic [`HE_MMIO_ADDR_W-1:0] eng_off;
    logic [`HE_MMIO_ADDR_W-1:0] eng_sel;
    logic                       eng_hit;
    eng_csr_e                   reg_idx;

    assign is_global = (mmio_addr < `HE_ENG_BASE);
    assign eng_off   = mmio_addr - `HE_ENG_BASE;
    assign eng_sel   = eng_off >> STRIDE_SHIFT;

    // Addresses past the last engine hit nothing
    assign eng_hit   = !is_global && (eng_sel < NUM_ENGINES);
    assign reg_idx   = eng_csr_e'(mmio_addr[3:0]);

    // Scratch register for host sanity checks
    logic [`HE_DATA_W-1:0] scratch;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            scratch <= '0;
        end
        else if (mmio_wr && (mmio_addr == 3))
        begin
            scratch <= mmio_wr_data;
        end
    end

    // ====================
    // Engine fan-out
    // ====================

    logic [`HE_DATA_W-1:0] eng_rd_word [NUM_ENGINES];

    for (genvar e = 0; e < NUM_ENGINES; e++)
    begin : g_eng
        // Write strobe passes through in the same cycle as mmio_wr
        assign eng_csr[e].wr_valid = mmio_wr && eng_hit && (eng_sel == e);
        assign eng_csr[e].wr_idx   = reg_idx;
        assign eng_csr[e].wr_data  = mmio_wr_data;

        // Pick this engine's addressed word ahead of the final mux
        assign eng_rd_word[e] = eng_csr[e].rd_data[reg_idx];
    end

    // Read word for the current address
    logic [`HE_DATA_W-1:0] rd_word;

    always_comb
    begin
        rd_word = '0;
        if (is_global)
        begin
            case (mmio_addr)
                0:       rd_word = `HE_TEST_ID_LO;
                1:       rd_word = `HE_TEST_ID_HI;
                2:       rd_word = ENG_COUNT;
                3:       rd_word = scratch;
                default: rd_word = '0;
            endcase
        end
        else if (eng_hit)
        begin
            for (int e = 0; e < NUM_ENGINES; e++)
            begin
                if (eng_sel == e)
                begin
                    rd_word = eng_rd_word[e];
                end
            end
        end
    end

    // Read response one cycle after the strobe
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            mmio_rd_valid <= 1'b0;
        end
        else
        begin
            mmio_rd_valid <= mmio_rd;
        end
    end

    always_ff @(posedge clk)
    begin
        if (mmio_rd)
        begin
            mmio_rd_data <= rd_word;
        end
    end

    // The window has a single address, shared by both strobes
    a_no_rd_wr: assert property (@(posedge clk) disable iff (!rst_n)
        !(mmio_wr && mmio_rd))
        else $error("host raised mmio_wr and mmio_rd together");

endmodule

`default_nettype wire

// ==== source/host_mem_rdwr_engine.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "host_exer_config.svh"

module host_mem_rdwr_engine import host_exer_pkg::*;
#(
    parameter int ENGINE_NUMBER = 0
)
(
    input  wire logic                  clk,
    input  wire logic                  rst_n,

    // Memory port with one line per request
    output logic                       mem_wr,
    output logic                       mem_rd,
    output logic [`HE_ADDR_W-1:0]      mem_addr,
    output logic [`HE_DATA_W-1:0]      mem_wr_data,
    input  wire logic                  mem_rsp_valid,
    input  wire logic [`HE_DATA_W-1:0] mem_rsp_data,

    // Register link from the manager
    engine_csr_if.engine               csrs
);

    // Zero padding from a line address up to a data word
    localparam int PAD_W = `HE_DATA_W - `HE_ADDR_W;

    // ====================
    // Host programmed registers
    // ====================

    eng_mode_e             mode;
    logic [`HE_ADDR_W-1:0] base;
    logic [`HE_ADDR_W-1:0] lines;
    logic [`HE_DATA_W-1:0] seed;

    // Run state
    eng_state_e            state;
    logic                  active;
    logic                  done;
    logic [`HE_ADDR_W-1:0] req_cnt;
    logic [`HE_ADDR_W-1:0] rsp_cnt;
    logic [`HE_DATA_W-1:0] checksum;
    logic [`HE_DATA_W-1:0] cycles;

    // Control decode
    logic                  ctrl_wr;
    logic                  start_req;
    eng_mode_e             new_mode;
    logic                  last_req;
    logic                  last_rsp;

    assign ctrl_wr   = csrs.wr_valid && (csrs.wr_idx == CSR_CTRL);
    assign new_mode  = eng_mode_e'(csrs.wr_data[1:0]);

    // A start is honoured only from idle and is dropped otherwise
    assign start_req = ctrl_wr && csrs.wr_data[8] && (state == ST_IDLE);

    assign active    = (state != ST_IDLE);
    assign last_req  = (req_cnt == lines - 1'b1);

    // Responses come back in order, so the count alone finds the last one
    assign last_rsp  = mem_rsp_valid && (rsp_cnt == lines - 1'b1);

    // Configuration writes change the mode only while idle
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            mode  <= MODE_READ;
            base  <= '0;
            lines <= '0;
            seed  <= '0;
        end
        else if (csrs.wr_valid)
        begin
            case (csrs.wr_idx)
                CSR_CTRL:  if (state == ST_IDLE) mode <= new_mode;
                CSR_BASE:  base  <= csrs.wr_data[`HE_ADDR_W-1:0];
                CSR_LINES: lines <= csrs.wr_data[`HE_ADDR_W-1:0];
                CSR_SEED:  seed  <= csrs.wr_data;
                default:   ;
            endcase
        end
    end

    // ====================
    // Sequencer
    // ====================

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state    <= ST_IDLE;
            done     <= 1'b0;
            req_cnt  <= '0;
            rsp_cnt  <= '0;
            checksum <= '0;
            cycles   <= '0;
        end
        else
        begin
            // Run time counts every cycle spent out of idle
            if (active)
            begin
                cycles <= cycles + 1'b1;
            end

            // Fold every returned line into the checksum
            if (mem_rsp_valid)
            begin
                checksum <= checksum ^ mem_rsp_data;
                rsp_cnt  <= rsp_cnt + 1'b1;
            end

            case (state)
                ST_IDLE:
                begin
                    if (start_req)
                    begin
                        checksum <= '0;
                        cycles   <= '0;
                        req_cnt  <= '0;
                        rsp_cnt  <= '0;
                        // An empty run is finished right away
                        done     <= (lines == '0);
                        if (lines != '0)
                        begin
                            state <= (new_mode == MODE_READ) ? ST_READ : ST_WRITE;
                        end
                    end
                end

                ST_WRITE:
                begin
                    req_cnt <= req_cnt + 1'b1;
                    if (last_req)
                    begin
                        req_cnt <= '0;
                        if (mode == MODE_RDWR)
                        begin
                            state <= ST_READ;
                        end
                        else
                        begin
                            state <= ST_IDLE;
                            done  <= 1'b1;
                        end
                    end
                end

                ST_READ:
                begin
                    req_cnt <= req_cnt + 1'b1;
                    if (last_req)
                    begin
                        state <= ST_DRAIN;
                    end
                end

                ST_DRAIN:
                begin
                    // Wait for the reads still in flight
                    if (last_rsp)
                    begin
                        state <= ST_IDLE;
                        done  <= 1'b1;
                    end
                end

                default: state <= ST_IDLE;
            endcase
        end
    end

    // Requests go out straight from the state at one per cycle
    assign mem_wr      = (state == ST_WRITE);
    assign mem_rd      = (state == ST_READ);
    assign mem_addr    = base + req_cnt;
    assign mem_wr_data = seed ^ {{PAD_W{1'b0}}, mem_addr};

    // Unused words of the readable register block stay zero
    always_comb
    begin
        for (int i = 0; i < csrs.NUM_CSRS; i++)
        begin
            csrs.rd_data[i] = '0;
        end
        csrs.rd_data[CSR_BASE]     = {{PAD_W{1'b0}}, base};
        csrs.rd_data[CSR_LINES]    = {{PAD_W{1'b0}}, lines};
        csrs.rd_data[CSR_SEED]     = seed;
        csrs.rd_data[CSR_STATUS]   = {{(`HE_DATA_W-2){1'b0}}, done, active};
        csrs.rd_data[CSR_CHECKSUM] = checksum;
        csrs.rd_data[CSR_CYCLES]   = cycles;
    end

    // ====================
    // Checks
    // ====================

    // A write in read mode or a read in write mode means the sequencer took the wrong path
    a_mode_request: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_wr && (mode == MODE_READ)) && !(mem_rd && (mode == MODE_WRITE)))
        else $error("engine %0d: request does not match the mode", ENGINE_NUMBER);

    // The memory must not answer more reads than the engine sent
    a_no_idle_rsp: assert property (@(posedge clk) disable iff (!rst_n)
        mem_rsp_valid |-> (state != ST_IDLE))
        else $error("engine %0d: response while idle", ENGINE_NUMBER);

endmodule

`default_nettype wire

// ==== source/engine_csr_if.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "host_exer_config.svh"

// Link between the register manager and one engine
interface engine_csr_if import host_exer_pkg::*; ();

    // Every engine exposes a block of 16 register words
    localparam int NUM_CSRS = 16;

    // Write path, driven by the manager for one cycle per write
    logic                  wr_valid;
    eng_csr_e              wr_idx;
    logic [`HE_DATA_W-1:0] wr_data;

    // Read path, all words driven continuously by the engine
    logic [`HE_DATA_W-1:0] rd_data [NUM_CSRS];

    // Manager side decodes MMIO and picks the read word
    modport mgr
    (
        output wr_valid, wr_idx, wr_data,
        input  rd_data
    );

    // Engine side owns the register contents
    modport engine
    (
        input  wr_valid, wr_idx, wr_data,
        output rd_data
    );

endinterface

`default_nettype wire

// ==== source/host_exer_pkg.sv ====
`default_nettype none

package host_exer_pkg;

    // Operation an engine runs after a start command
    typedef enum logic [1:0]
    {
        MODE_READ  = 2'd0,
        MODE_WRITE = 2'd1,
        MODE_RDWR  = 2'd2
    } eng_mode_e;

    // Engine sequencer states
    typedef enum logic [1:0]
    {
        ST_IDLE  = 2'd0,
        ST_WRITE = 2'd1,
        ST_READ  = 2'd2,
        ST_DRAIN = 2'd3
    } eng_state_e;

    // Register index inside one engine block
    // Indices 7 to 15 are unused and read as zero
    typedef enum logic [3:0]
    {
        CSR_CTRL     = 4'd0,
        CSR_BASE     = 4'd1,
        CSR_LINES    = 4'd2,
        CSR_SEED     = 4'd3,
        CSR_STATUS   = 4'd4,
        CSR_CHECKSUM = 4'd5,
        CSR_CYCLES   = 4'd6
    } eng_csr_e;

endpackage

`default_nettype wire

// ==== source/host_exer_config.svh ====
`ifndef HOST_EXER_CONFIG_SVH
`define HOST_EXER_CONFIG_SVH

// Register and memory data width
`define HE_DATA_W 64

// Line address width of one memory port
`define HE_ADDR_W 16

// Word address width of the register window
`define HE_MMIO_ADDR_W 8

// Number of memory exercise engines, one memory port each
`define HE_NUM_ENGINES 2

// Register map: globals sit below the first engine block
`define HE_ENG_BASE 16
`define HE_ENG_STRIDE 16

// Fixed 128-bit test ID, split into two register words
`define HE_TEST_ID_LO 64'h9e3c_51d7_a04b_62f8
`define HE_TEST_ID_HI 64'h3b7a_c2e1_58d4_0f96

`endif
